// ==== design/st_audio_mix.sv ====
module st_audio_mix (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic                  psg_stereo_i,  // a left, c right, b both
	input  st_glue_pkg::ym_chan_t ym_a_i,
	input  st_glue_pkg::ym_chan_t ym_b_i,
	input  st_glue_pkg::ym_chan_t ym_c_i,
	input  st_glue_pkg::dma_snd_t dma_l_i,
	input  st_glue_pkg::dma_snd_t dma_r_i,
	output st_glue_pkg::mix_t     mix_l_o,
	output st_glue_pkg::mix_t     mix_r_o
);
	import st_glue_pkg::*;

	logic [9:0] ym_l;  // unsigned channel sums
	logic [9:0] ym_r;
	logic [9:0] ym_ab;
	logic [9:0] ym_cb;

	// recentre both sources, then widen to 15 bits by repeating the
	// top bits below so full scale stays near full scale
	function automatic mix_t mix_one(input logic [9:0] ym, input dma_snd_t dma);
		logic [9:0] ym_s;
		logic [7:0] dma_s;
		ym_s    = ym - YM_MID;
		dma_s   = dma - DMA_MID;
		mix_one = {ym_s[9], ym_s, ym_s[9:6]} + {dma_s[7], dma_s, dma_s[7:2]};  // wraps
	endfunction

	assign ym_ab = {2'b00, ym_a_i} + {2'b00, ym_b_i};
	assign ym_cb = {2'b00, ym_c_i} + {2'b00, ym_b_i};

	always_comb begin
		if (psg_stereo_i) begin
			ym_l = ym_ab;
			ym_r = ym_cb;
		end else begin
			ym_l = ym_ab + {2'b00, ym_c_i};  // mono, all three both sides
			ym_r = ym_l;
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_l_o <= '0;
			mix_r_o <= '0;
		end else begin
			mix_l_o <= mix_one(ym_l, dma_l_i);
			mix_r_o <= mix_one(ym_r, dma_r_i);
		end
	end

endmodule

// ==== design/st_config_decode.sv ====
module st_config_decode (
	input  st_glue_pkg::sys_ctrl_t sys_ctrl_i,
	output logic                   ste_o,
	output logic                   mste_o,
	output logic                   steroids_o,
	output logic                   viking_enable_o,
	output logic                   psg_stereo_o,
	output st_glue_pkg::ram_size_e ram_size_o
);
	import st_glue_pkg::*;

	logic [2:0] ram_code;       // raw size field
	logic       viking_mem_ok;  // viking can't coexist with 14M

	assign ram_code = sys_ctrl_i[CTRL_RAM_HI:CTRL_RAM_LO];

	// machine flavour
	assign ste_o        = sys_ctrl_i[CTRL_STE] || sys_ctrl_i[CTRL_MSTE];
	assign mste_o       = sys_ctrl_i[CTRL_MSTE];
	assign steroids_o   = sys_ctrl_i[CTRL_STE] && sys_ctrl_i[CTRL_MSTE];  // ste on steroids
	assign psg_stereo_o = sys_ctrl_i[CTRL_PSG_STEREO];

	always_comb begin
		case (ram_code)
			3'd0:    ram_size_o = RAM_512K;
			3'd1:    ram_size_o = RAM_1M;
			3'd2:    ram_size_o = RAM_2M;
			3'd3:    ram_size_o = RAM_4M;
			3'd4:    ram_size_o = RAM_8M;
			3'd5:    ram_size_o = RAM_14M;
			default: ram_size_o = RAM_512K;  // unused codes, smallest window
		endcase
	end

	// the viking frame buffer sits at $c00000, which overlaps 14M ram
	always_comb begin
		case (ram_size_o)
			RAM_512K, RAM_1M, RAM_2M, RAM_4M, RAM_8M: viking_mem_ok = 1'b1;
			default:                                  viking_mem_ok = 1'b0;
		endcase
	end

	// steroids moves the card up to $e80000 so it is always allowed
	assign viking_enable_o = (sys_ctrl_i[CTRL_VIKING] && viking_mem_ok) || steroids_o;

endmodule

// ==== design/st_glue_pkg.sv ====
package st_glue_pkg;

	// bus side widths
	typedef logic [31:0] sys_ctrl_t;   // control word from io controller
	typedef logic [23:1] word_addr_t;  // 68000 word address
	typedef logic [15:0] word_t;

	// bus cycle number from the mcu, one slot per 8 MHz phase group
	typedef logic [1:0] bus_slot_t;

	localparam bus_slot_t SLOT_PRE   = 2'd0;  // cpu precycle
	localparam bus_slot_t SLOT_CPU   = 2'd1;
	localparam bus_slot_t SLOT_VIDEO = 2'd2;  // shifter and viking share this one

	// ram size as coded in the control word
	typedef enum logic [2:0] {
		RAM_512K = 3'd0,
		RAM_1M   = 3'd1,
		RAM_2M   = 3'd2,
		RAM_4M   = 3'd3,
		RAM_8M   = 3'd4,
		RAM_14M  = 3'd5
	} ram_size_e;

	// audio
	typedef logic [7:0]         ym_chan_t;  // unsigned psg level
	typedef logic [7:0]         dma_snd_t;  // unsigned ste dma sample
	typedef logic signed [14:0] mix_t;      // to the sigma-delta dac

	// control word bit positions
	localparam int CTRL_RESET      = 0;
	localparam int CTRL_RAM_LO     = 1;
	localparam int CTRL_RAM_HI     = 3;
	localparam int CTRL_SCANLINES  = 20;
	localparam int CTRL_PSG_STEREO = 22;
	localparam int CTRL_STE        = 23;
	localparam int CTRL_MSTE       = 24;
	localparam int CTRL_VIKING     = 28;

	// accesses needed before we believe a viking driver is running
	localparam logic [7:0] VIKING_HITS = 8'd255;

	// address tags, bits 23:18
	localparam logic [5:0] VIKING_BASE_LO = 6'b110000;  // $c0xxxx
	localparam logic [5:0] VIKING_BASE_HI = 6'b111010;  // $e8xxxx
	localparam logic [5:0] TOS192_TAG     = 6'b111111;  // $fcxxxx

	// bits 23:20, 256k tos lives at $e00000
	localparam logic [3:0] TOS256_TAG = 4'he;

	// midpoints for recentring unsigned audio
	localparam logic [9:0] YM_MID  = 10'd512;
	localparam logic [7:0] DMA_MID = 8'd128;

endpackage

// ==== design/st_glue_top.sv ====
module st_glue_top (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  st_glue_pkg::sys_ctrl_t  sys_ctrl_i,
	input  logic                    clk_8_en_i,
	input  st_glue_pkg::bus_slot_t  bus_slot_i,
	input  logic                    as_n_i,
	input  logic                    rom2_n_i,
	input  st_glue_pkg::word_addr_t cpu_addr_i,
	input  logic                    dl_strobe_i,
	input  logic                    download_i,
	input  st_glue_pkg::word_addr_t dl_addr_i,
	input  st_glue_pkg::word_t      dl_din_i,
	input  logic                    ras_n_i,
	input  logic                    mcu_we_n_i,
	input  logic                    mcu_uds_i,
	input  logic                    mcu_lds_i,
	input  st_glue_pkg::word_addr_t mcu_addr_i,
	input  st_glue_pkg::word_t      mcu_din_i,
	input  logic                    blt_has_bus_i,
	input  logic                    blt_read_i,
	input  logic                    blt_write_i,
	input  st_glue_pkg::word_addr_t blt_addr_i,
	input  st_glue_pkg::word_t      blt_din_i,
	input  logic                    vik_read_i,
	input  st_glue_pkg::word_addr_t vik_addr_i,
	input  st_glue_pkg::ym_chan_t   ym_a_i,
	input  st_glue_pkg::ym_chan_t   ym_b_i,
	input  st_glue_pkg::ym_chan_t   ym_c_i,
	input  st_glue_pkg::dma_snd_t   dma_l_i,
	input  st_glue_pkg::dma_snd_t   dma_r_i,
	output logic                    viking_active_o,  // switches video source
	output st_glue_pkg::word_addr_t rom_addr_o,
	output st_glue_pkg::word_addr_t sdram_addr_o,
	output st_glue_pkg::word_t      sdram_din_o,
	output logic                    sdram_oe_o,
	output logic                    sdram_we_o,
	output logic                    sdram_uds_o,
	output logic                    sdram_lds_o,
	output st_glue_pkg::mix_t       mix_l_o,
	output st_glue_pkg::mix_t       mix_r_o
);
	import st_glue_pkg::*;

	logic      sys_reset;
	logic      steroids;
	logic      viking_enable;
	logic      psg_stereo;
	ram_size_e ram_size;
	logic      dl_wr;

	assign sys_reset = sys_ctrl_i[CTRL_RESET];

	// ste/mste only steer chipset blocks outside this glue
	st_config_decode st_config_decode_i (.sys_ctrl_i(sys_ctrl_i), .ste_o(), .mste_o(),
		.steroids_o(steroids), .viking_enable_o(viking_enable),
		.psg_stereo_o(psg_stereo), .ram_size_o(ram_size));

	st_viking_detect st_viking_detect_i (.clk_32(clk_32), .xsint(xsint),
		.sys_reset_i(sys_reset), .clk_8_en_i(clk_8_en_i), .as_n_i(as_n_i),
		.viking_enable_i(viking_enable), .steroids_i(steroids), .cpu_addr_i(cpu_addr_i),
		.viking_active_o(viking_active_o));

	st_tos_upload st_tos_upload_i (.clk_32(clk_32), .xsint(xsint), .clk_8_en_i(clk_8_en_i),
		.dl_strobe_i(dl_strobe_i), .download_i(download_i), .rom2_n_i(rom2_n_i),
		.bus_slot_i(bus_slot_i), .dl_addr_i(dl_addr_i), .cpu_addr_i(cpu_addr_i),
		.dl_wr_o(dl_wr), .rom_addr_o(rom_addr_o));

	st_ram_arbiter st_ram_arbiter_i (.clk_32(clk_32), .xsint(xsint), .bus_slot_i(bus_slot_i),
		.ram_size_i(ram_size), .mcu_addr_i(mcu_addr_i), .blt_addr_i(blt_addr_i),
		.vik_addr_i(vik_addr_i), .dl_addr_i(dl_addr_i), .mcu_din_i(mcu_din_i),
		.blt_din_i(blt_din_i), .dl_din_i(dl_din_i), .ras_n_i(ras_n_i), .mcu_we_n_i(mcu_we_n_i),
		.mcu_uds_i(mcu_uds_i), .mcu_lds_i(mcu_lds_i), .blt_has_bus_i(blt_has_bus_i),
		.blt_read_i(blt_read_i), .blt_write_i(blt_write_i), .vik_read_i(vik_read_i),
		.viking_active_i(viking_active_o), .download_i(download_i), .dl_wr_i(dl_wr),
		.sdram_addr_o(sdram_addr_o), .sdram_din_o(sdram_din_o), .sdram_oe_o(sdram_oe_o),
		.sdram_we_o(sdram_we_o), .sdram_uds_o(sdram_uds_o), .sdram_lds_o(sdram_lds_o));

	st_audio_mix st_audio_mix_i (.clk_32(clk_32), .xsint(xsint), .psg_stereo_i(psg_stereo),
		.ym_a_i(ym_a_i), .ym_b_i(ym_b_i), .ym_c_i(ym_c_i), .dma_l_i(dma_l_i),
		.dma_r_i(dma_r_i), .mix_l_o(mix_l_o), .mix_r_o(mix_r_o));

endmodule

// ==== design/st_ram_arbiter.sv ====
module st_ram_arbiter (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  st_glue_pkg::bus_slot_t  bus_slot_i,
	input  st_glue_pkg::ram_size_e  ram_size_i,
	input  st_glue_pkg::word_addr_t mcu_addr_i,
	input  st_glue_pkg::word_addr_t blt_addr_i,
	input  st_glue_pkg::word_addr_t vik_addr_i,
	input  st_glue_pkg::word_addr_t dl_addr_i,
	input  st_glue_pkg::word_t      mcu_din_i,
	input  st_glue_pkg::word_t      blt_din_i,
	input  st_glue_pkg::word_t      dl_din_i,
	input  logic                    ras_n_i,        // ras0_n & ras1_n
	input  logic                    mcu_we_n_i,
	input  logic                    mcu_uds_i,
	input  logic                    mcu_lds_i,
	input  logic                    blt_has_bus_i,
	input  logic                    blt_read_i,
	input  logic                    blt_write_i,
	input  logic                    vik_read_i,
	input  logic                    viking_active_i,
	input  logic                    download_i,
	input  logic                    dl_wr_i,        // pulse from upload logic
	output st_glue_pkg::word_addr_t sdram_addr_o,
	output st_glue_pkg::word_t      sdram_din_o,
	output logic                    sdram_oe_o,
	output logic                    sdram_we_o,
	output logic                    sdram_uds_o,
	output logic                    sdram_lds_o
);
	import st_glue_pkg::*;

	logic ras_n_q;    // ras one clock ago
	logic ram_start;  // falling ras edge
	logic ram_oe;
	logic ram_we;
	logic ram_en;     // mcu address inside fitted ram
	logic cpu_cycle;
	logic dl_sel;
	logic blt_sel;
	logic vik_sel;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			ras_n_q <= 1'b0;  // no access until ras has been seen high
		else
			ras_n_q <= ras_n_i;
	end

	assign ram_start = ras_n_q & ~ras_n_i;
	assign ram_oe    = ram_start & mcu_we_n_i & (|mcu_addr_i);  // address 0 never read
	assign ram_we    = ram_start & ~mcu_we_n_i;

	// window check, each size allows everything below its top
	always_comb begin
		case (ram_size_i)
			RAM_512K: ram_en = (mcu_addr_i[23:19] == 5'b00000);
			RAM_1M:   ram_en = (mcu_addr_i[23:20] == 4'b0000);
			RAM_2M:   ram_en = (mcu_addr_i[23:21] == 3'b000);
			RAM_4M:   ram_en = (mcu_addr_i[23:22] == 2'b00);
			RAM_8M:   ram_en = !mcu_addr_i[23];
			RAM_14M:  ram_en = !(&mcu_addr_i[23:21]);  // up to $dfffff
			default:  ram_en = 1'b0;
		endcase
	end

	// who owns the slot
	assign cpu_cycle = (bus_slot_i == SLOT_CPU);
	assign dl_sel    = cpu_cycle & download_i;     // upload wins everything
	assign blt_sel   = cpu_cycle & blt_has_bus_i;
	assign vik_sel   = (bus_slot_i == SLOT_VIDEO) & viking_active_i & vik_read_i;

	always_comb begin
		// mcu by default, gated by the window
		sdram_addr_o = mcu_addr_i;
		sdram_oe_o   = ram_oe & ram_en;
		sdram_we_o   = ram_we & ram_en;
		sdram_uds_o  = mcu_uds_i;
		sdram_lds_o  = mcu_lds_i;
		if (dl_sel) begin
			sdram_addr_o = dl_addr_i;
			sdram_oe_o   = 1'b0;
			sdram_we_o   = dl_wr_i;
			sdram_uds_o  = 1'b1;  // always whole words
			sdram_lds_o  = 1'b1;
		end else if (blt_sel) begin
			sdram_addr_o = blt_addr_i;
			sdram_oe_o   = blt_read_i;
			sdram_we_o   = blt_write_i;
			sdram_uds_o  = 1'b1;
			sdram_lds_o  = 1'b1;
		end else if (vik_sel) begin
			sdram_addr_o = vik_addr_i;  // 64 bit burst fetch
			sdram_oe_o   = 1'b1;
		end
	end

	// write data not tied to the slot, only writers in their slot use it
	always_comb begin
		if (download_i)
			sdram_din_o = dl_din_i;
		else if (blt_has_bus_i)
			sdram_din_o = blt_din_i;
		else
			sdram_din_o = mcu_din_i;
	end

endmodule

// ==== design/st_tos_upload.sv ====
module st_tos_upload (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  logic                    clk_8_en_i,
	input  logic                    dl_strobe_i,  // toggles once per word
	input  logic                    download_i,
	input  logic                    rom2_n_i,     // tos rom select from mcu
	input  st_glue_pkg::bus_slot_t  bus_slot_i,
	input  st_glue_pkg::word_addr_t dl_addr_i,
	input  st_glue_pkg::word_addr_t cpu_addr_i,
	output logic                    dl_wr_o,
	output st_glue_pkg::word_addr_t rom_addr_o
);
	import st_glue_pkg::*;

	logic       strobe_q;  // strobe as seen at the last precycle
	logic       pre_tick;  // sample point
	logic       tos192k;   // image loaded at $fc0000
	logic [5:0] rom_bank;  // bits 23:18 of the remapped address

	// the strobe comes from the spi clock domain, so only look at it
	// once per bus cycle; the write then lands in the following cpu slot
	assign pre_tick = (bus_slot_i == SLOT_PRE) && clk_8_en_i;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			strobe_q <= 1'b0;
			dl_wr_o  <= 1'b0;
		end else begin
			dl_wr_o <= 1'b0;  // single clock pulse
			if (pre_tick) begin
				strobe_q <= dl_strobe_i;
				if (dl_strobe_i != strobe_q)
					dl_wr_o <= 1'b1;
			end
		end
	end

	// image address tells which tos flavour is coming in
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k <= 1'b0;
		end else if (download_i) begin
			if (dl_addr_i[23:18] == TOS192_TAG)
				tos192k <= 1'b1;  // st tos 1.x
			else if (dl_addr_i[23:20] == TOS256_TAG)
				tos192k <= 1'b0;  // ste tos at $e00000
		end
	end

	// rom2 window maps onto whichever bank the image was loaded to
	assign rom_bank = tos192k ? TOS192_TAG : {TOS256_TAG, 2'b00};

	always_comb begin
		if (!rom2_n_i)
			rom_addr_o = {rom_bank, cpu_addr_i[17:1]};
		else
			rom_addr_o = cpu_addr_i;  // other roms and cartridge as is
	end

endmodule

// ==== design/st_viking_detect.sv ====
module st_viking_detect (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  logic                    sys_reset_i,      // core reset from io controller
	input  logic                    clk_8_en_i,       // 8 MHz bus enable
	input  logic                    as_n_i,
	input  logic                    viking_enable_i,
	input  logic                    steroids_i,       // selects the high base
	input  st_glue_pkg::word_addr_t cpu_addr_i,
	output logic                    viking_active_o
);
	import st_glue_pkg::*;

	logic [7:0] hit_cnt;   // saturating access count
	logic [5:0] tag_want;  // window the driver should hit
	logic       tag_hit;
	logic       hit;

	// tos probes the area too, so a single access means nothing
	assign tag_want = steroids_i ? VIKING_BASE_HI : VIKING_BASE_LO;
	assign tag_hit  = (cpu_addr_i[23:18] == tag_want);

	assign hit = clk_8_en_i && !as_n_i && viking_enable_i && tag_hit &&
		(hit_cnt != VIKING_HITS);  // stop at saturation

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			hit_cnt         <= 8'd0;
			viking_active_o <= 1'b0;
		end else if (sys_reset_i) begin  // machine reset drops back to shifter video
			hit_cnt         <= 8'd0;
			viking_active_o <= 1'b0;
		end else begin
			if (hit)
				hit_cnt <= hit_cnt + 8'd1;
			viking_active_o <= (hit_cnt == VIKING_HITS);  // one clock behind the count
		end
	end

endmodule

// ==== filelist.f ====
design/st_glue_pkg.sv
design/st_config_decode.sv
design/st_viking_detect.sv
design/st_tos_upload.sv
design/st_ram_arbiter.sv
design/st_audio_mix.sv
design/st_glue_top.sv
test/st_glue_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the glue testbench with verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module st_glue_tb -o st_glue_sim > sim.log 2>&1 &&
	./obj_dir/st_glue_sim >> sim.log 2>&1 ||
	{ cat sim.log; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1
exit 0

// ==== test/st_glue_tb.sv ====
module st_glue_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import st_glue_pkg::*;

	logic       clk_32;
	logic       xsint;
	sys_ctrl_t  sys_ctrl_i;
	bus_slot_t  bus_slot_i;
	logic       clk_8_en_i, as_n_i, rom2_n_i, dl_strobe_i, download_i;
	logic       ras_n_i, mcu_we_n_i, mcu_uds_i, mcu_lds_i;
	logic       blt_has_bus_i, blt_read_i, blt_write_i, vik_read_i;
	word_addr_t cpu_addr_i, dl_addr_i, mcu_addr_i, blt_addr_i, vik_addr_i;
	word_t      dl_din_i, mcu_din_i, blt_din_i;
	ym_chan_t   ym_a_i, ym_b_i, ym_c_i;
	dma_snd_t   dma_l_i, dma_r_i;
	logic       viking_active_o, sdram_oe_o, sdram_we_o, sdram_uds_o, sdram_lds_o;
	word_addr_t rom_addr_o, sdram_addr_o;
	word_t      sdram_din_o;
	mix_t       mix_l_o, mix_r_o;

	integer seed;
	int     n_checks;
	int     n_errors;
	int     we_pulses;     // negedges with sdram_we_o high
	mix_t   exp_l, exp_r;  // reference mixer, one clock behind the inputs

	st_glue_top st_glue_top_i (.*);

	always #4 clk_32 = ~clk_32;  // 125 MHz stand-in for the 32 MHz clock

	always @(negedge clk_32) begin
		if (sdram_we_o === 1'b1)
			we_pulses++;
	end

	// level centred on the midpoint and scaled to 15 bits with the top bits copied below
	function automatic logic [14:0] mix_ref(input int ym_sum, input int dma);
		int ym_c;
		int dma_c;
		int total;
		ym_c  = ym_sum - 512;
		dma_c = dma - 128;
		total = ym_c * 16 + ((ym_c & 'h3ff) >> 6) + dma_c * 64 + ((dma_c & 'hff) >> 2);
		return 15'(total);  // wraps mod 2^15
	endfunction

	always @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			exp_l <= '0;
			exp_r <= '0;
		end else if (sys_ctrl_i[CTRL_PSG_STEREO]) begin  // a+b left, c+b right
			exp_l <= mix_ref(int'(ym_a_i) + int'(ym_b_i), int'(dma_l_i));
			exp_r <= mix_ref(int'(ym_c_i) + int'(ym_b_i), int'(dma_r_i));
		end else begin
			exp_l <= mix_ref(int'(ym_a_i) + int'(ym_b_i) + int'(ym_c_i), int'(dma_l_i));
			exp_r <= mix_ref(int'(ym_a_i) + int'(ym_b_i) + int'(ym_c_i), int'(dma_r_i));
		end
	end

	assert property (@(posedge clk_32) disable iff (!xsint) mix_l_o == exp_l)
	else begin
		n_errors++;
		$display("FAIL %0t mix_l_o expected %h got %h", $time, $sampled(exp_l), $sampled(mix_l_o));
	end

	assert property (@(posedge clk_32) disable iff (!xsint) mix_r_o == exp_r)
	else begin
		n_errors++;
		$display("FAIL %0t mix_r_o expected %h got %h", $time, $sampled(exp_r), $sampled(mix_r_o));
	end

	task automatic check_equal(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		n_checks++;
		assert (act_v === exp_v)
		else begin
			n_errors++;
			$display("FAIL %0t %s expected %h got %h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_bus(input word_addr_t addr, input word_t din, input logic oe,
			input logic we, input logic uds, input logic lds);
		check_equal("sdram_addr_o", addr, sdram_addr_o);
		check_equal("sdram_din_o", din, sdram_din_o);
		check_equal("sdram_oe_o", oe, sdram_oe_o);
		check_equal("sdram_we_o", we, sdram_we_o);
		check_equal("sdram_uds_o", uds, sdram_uds_o);
		check_equal("sdram_lds_o", lds, sdram_lds_o);
	endtask

	// rom2 window lands in bank e0 or fc and keeps the low 18 byte bits
	function automatic word_addr_t rom_expect(input logic [7:0] bank, input word_addr_t cpu);
		logic [23:0] byte_addr;
		byte_addr = {bank, 16'h0000} | ({cpu, 1'b0} & 24'h03ffff);
		return byte_addr[23:1];
	endfunction

	function automatic int unsigned ram_top(input int sz);
		case (sz)
			0:       return 32'h0008_0000;
			1:       return 32'h0010_0000;
			2:       return 32'h0020_0000;
			3:       return 32'h0040_0000;
			4:       return 32'h0080_0000;
			default: return 32'h00e0_0000;  // 14M stops at the rom area
		endcase
	endfunction

	task automatic send_precycle();
		@(posedge clk_32);
		bus_slot_i <= SLOT_PRE;
		clk_8_en_i <= 1'b1;
		@(posedge clk_32);
		bus_slot_i <= SLOT_CPU;  // write lands here
		clk_8_en_i <= 1'b0;
	endtask

	task automatic wait_we_pulse(input int limit, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk_32);
			cycles++;
		end while (sdram_we_o !== 1'b1 && cycles < limit);
		if (sdram_we_o !== 1'b1) begin
			n_errors++;
			$display("timeout, no sdram write followed the precycle");
		end
	endtask

	task automatic wait_viking(input int limit, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk_32);
			cycles++;
		end while (viking_active_o !== 1'b1 && cycles < limit);
		if (viking_active_o !== 1'b1) begin
			n_errors++;
			$display("timeout, viking_active_o never rose");
		end
	endtask

	task automatic run_accesses(input logic [5:0] tag, input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_32);
			as_n_i     <= 1'b0;
			clk_8_en_i <= 1'b1;
			cpu_addr_i <= {tag, 17'($random(seed))};
		end
		@(posedge clk_32);
		as_n_i     <= 1'b1;
		clk_8_en_i <= 1'b0;
	endtask

	initial begin
		int unsigned top;
		int unsigned tmp;
		word_addr_t  addr, a_dl, a_blt, a_mcu, a_vik;
		word_t       d_dl, d_blt, d_mcu;
		int          cyc;
		seed = 32'h7a5e_5002;
		n_checks = 0;
		n_errors = 0;
		clk_32 = 1'b0;
		xsint = 1'b0;
		sys_ctrl_i = '0;
		bus_slot_i = SLOT_VIDEO;
		{clk_8_en_i, rom2_n_i, dl_strobe_i, download_i} = 4'b0000;  // rom2 selected
		{as_n_i, ras_n_i, mcu_we_n_i, mcu_uds_i, mcu_lds_i} = 5'b11111;
		{blt_has_bus_i, blt_read_i, blt_write_i, vik_read_i} = 4'b0000;
		cpu_addr_i = word_addr_t'($random(seed));
		{dl_addr_i, mcu_addr_i, blt_addr_i, vik_addr_i} = '0;
		{dl_din_i, mcu_din_i, blt_din_i} = '0;
		{ym_a_i, ym_b_i, ym_c_i, dma_l_i, dma_r_i} = '0;
		repeat (2) @(posedge clk_32);
		xsint <= 1'b1;
		@(negedge clk_32);
		check_equal("viking_active_o", 0, viking_active_o);
		check_equal("sdram_we_o", 0, sdram_we_o);
		check_equal("mix_l_o", 0, mix_l_o);
		check_equal("mix_r_o", 0, mix_r_o);
		check_equal("rom_addr_o", rom_expect(8'he0, cpu_addr_i), rom_addr_o);

		// mcu reads and writes on a ras falling edge in the video slot
		for (int sz = 0; sz < 6; sz++) begin
			top = ram_top(sz);
			for (int k = 0; k < 3; k++) begin
				tmp  = $unsigned($random(seed)) % top;
				addr = (k == 0) ? word_addr_t'($random(seed)) : (k == 1) ? tmp[23:1] : '0;
				@(posedge clk_32);
				sys_ctrl_i <= sys_ctrl_t'(sz) << CTRL_RAM_LO;
				mcu_addr_i <= addr;
				mcu_we_n_i <= 1'b1;
				ras_n_i    <= 1'b1;
				@(posedge clk_32);
				ras_n_i <= 1'b0;
				@(negedge clk_32);
				check_equal("sdram_oe_o", (addr != '0) && ({addr, 1'b0} < top), sdram_oe_o);
				@(negedge clk_32);
				check_equal("sdram_oe_o", 0, sdram_oe_o);  // ras still low, no new access
				@(posedge clk_32);
				mcu_we_n_i <= 1'b0;
				ras_n_i    <= 1'b1;
				@(posedge clk_32);
				ras_n_i <= 1'b0;
				@(negedge clk_32);
				check_equal("sdram_we_o", {addr, 1'b0} < top, sdram_we_o);  // address 0 writable
				check_equal("sdram_oe_o", 0, sdram_oe_o);
			end
		end

		// download beats blitter beats mcu in the cpu slot
		a_dl  = word_addr_t'($random(seed));
		a_blt = word_addr_t'($random(seed));
		a_mcu = word_addr_t'($random(seed));
		a_vik = word_addr_t'($random(seed));
		d_dl  = word_t'($random(seed));
		d_blt = word_t'($random(seed));
		d_mcu = word_t'($random(seed));
		@(posedge clk_32);
		sys_ctrl_i <= '0;
		ras_n_i    <= 1'b1;
		mcu_we_n_i <= 1'b1;
		bus_slot_i <= SLOT_CPU;
		{dl_addr_i, blt_addr_i, mcu_addr_i, vik_addr_i} <= {a_dl, a_blt, a_mcu, a_vik};
		{dl_din_i, blt_din_i, mcu_din_i} <= {d_dl, d_blt, d_mcu};
		{download_i, blt_has_bus_i, blt_read_i, blt_write_i} <= 4'b1111;
		{mcu_uds_i, mcu_lds_i} <= 2'b01;
		@(negedge clk_32);
		check_bus(a_dl, d_dl, 1'b0, 1'b0, 1'b1, 1'b1);  // no strobe toggle yet
		@(posedge clk_32);
		download_i <= 1'b0;
		@(negedge clk_32);
		check_bus(a_blt, d_blt, 1'b1, 1'b1, 1'b1, 1'b1);
		@(posedge clk_32);
		blt_has_bus_i <= 1'b0;
		@(negedge clk_32);
		check_bus(a_mcu, d_mcu, 1'b0, 1'b0, 1'b0, 1'b1);
		@(posedge clk_32);
		bus_slot_i <= SLOT_VIDEO;
		vik_read_i <= 1'b1;
		@(negedge clk_32);
		check_bus(a_mcu, d_mcu, 1'b0, 1'b0, 1'b0, 1'b1);  // viking not active yet

		// one upload write per strobe toggle
		@(posedge clk_32);
		bus_slot_i  <= SLOT_CPU;
		vik_read_i  <= 1'b0;
		download_i  <= 1'b1;
		dl_addr_i   <= {TOS192_TAG, 17'($random(seed))};
		dl_strobe_i <= 1'b1;
		we_pulses = 0;
		repeat (3) @(posedge clk_32);
		check_equal("sdram_we_o pulses", 0, we_pulses);  // toggle alone writes nothing
		send_precycle();
		wait_we_pulse(8, cyc);
		check_equal("sdram_we_o delay", 1, cyc);
		repeat (4) @(posedge clk_32);
		send_precycle();
		repeat (4) @(posedge clk_32);
		check_equal("sdram_we_o pulses", 1, we_pulses);
		@(negedge clk_32);
		check_equal("rom_addr_o", rom_expect(8'hfc, cpu_addr_i), rom_addr_o);
		@(posedge clk_32);
		dl_addr_i <= {TOS256_TAG, 19'($random(seed))};
		repeat (2) @(negedge clk_32);
		check_equal("rom_addr_o", rom_expect(8'he0, cpu_addr_i), rom_addr_o);
		@(posedge clk_32);
		rom2_n_i   <= 1'b1;
		download_i <= 1'b0;
		@(negedge clk_32);
		check_equal("rom_addr_o", cpu_addr_i, rom_addr_o);  // passthrough

		// random audio in mono and then in stereo
		for (int i = 0; i < 40; i++) begin
			@(posedge clk_32);
			sys_ctrl_i <= (i >= 20) ? (32'd1 << CTRL_PSG_STEREO) : '0;
			{ym_a_i, ym_b_i, ym_c_i} <= 24'($random(seed));
			{dma_l_i, dma_r_i} <= 16'($random(seed));
		end

		// ram code 0 so bit 28 alone enables viking
		@(posedge clk_32);
		sys_ctrl_i <= 32'd1 << CTRL_VIKING;
		bus_slot_i <= SLOT_VIDEO;
		run_accesses(VIKING_BASE_HI, 300);  // wrong tag without steroids
		run_accesses(VIKING_BASE_LO, 254);
		repeat (3) @(negedge clk_32);
		check_equal("viking_active_o", 0, viking_active_o);
		run_accesses(VIKING_BASE_LO, 1);
		@(negedge clk_32);
		check_equal("viking_active_o", 0, viking_active_o);  // count just saturated
		wait_viking(8, cyc);
		check_equal("viking_active_o delay", 1, cyc);
		run_accesses(VIKING_BASE_LO, 4);  // count holds at 255
		repeat (2) @(negedge clk_32);
		check_equal("viking_active_o", 1, viking_active_o);

		// steroids at 14M moves the tag up to e8
		@(posedge clk_32);
		sys_ctrl_i <= (32'd1 << CTRL_STE) | (32'd1 << CTRL_MSTE) | (32'd5 << CTRL_RAM_LO) | 32'd1;
		@(posedge clk_32);
		sys_ctrl_i[CTRL_RESET] <= 1'b0;
		@(negedge clk_32);
		check_equal("viking_active_o", 0, viking_active_o);
		run_accesses(VIKING_BASE_LO, 300);
		repeat (3) @(negedge clk_32);
		check_equal("viking_active_o", 0, viking_active_o);
		run_accesses(VIKING_BASE_HI, 255);
		wait_viking(8, cyc);
		check_equal("viking_active_o delay", 2, cyc);

		// video slot now goes to the viking fetch
		@(posedge clk_32);
		vik_read_i <= 1'b1;
		@(negedge clk_32);
		check_bus(a_vik, d_mcu, 1'b1, 1'b0, 1'b0, 1'b1);
		@(posedge clk_32);
		vik_read_i <= 1'b0;
		@(negedge clk_32);
		check_bus(a_mcu, d_mcu, 1'b0, 1'b0, 1'b0, 1'b1);

		repeat (2) @(posedge clk_32);
		$display("checks %0d errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule
